// File: rtl/trs_io_pkg.sv
package trs_io_pkg;

  localparam int byte_w     = 8;      // one spi transfer
  localparam int mem_addr_w = 15;
  localparam int mem_depth  = 32768;  // 32 KiB shadow ram
  localparam int max_params = 3;      // bram_poke is the longest command
  localparam int conf_w     = 4;

  // fixed reply values
  localparam logic [byte_w-1:0] cookie_val = 8'hAF;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  // command codes as sent by the controller
  typedef enum logic [byte_w-1:0] {
    get_cookie  = 8'd0,
    bram_poke   = 8'd1,   // addr lo, addr hi, data
    bram_peek   = 8'd2,   // addr lo, addr hi
    get_version = 8'd15,
    set_led     = 8'd26,  // rgb in bits 0..2
    get_config  = 8'd27
  } opcode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_read_bytes,
    st_execute
  } ctrl_state_e;

endpackage

// File: rtl/spi_byte_if.sv
`timescale 1ns/1ps

interface spi_byte_if;
  logic [trs_io_pkg::byte_w-1:0] rx_data;
  logic                          rx_valid;   // one pulse per received byte
  logic                          frame_end;  // cs_n went high
  logic [trs_io_pkg::byte_w-1:0] tx_data;
  logic                          tx_valid;
  logic                          tx_ready;   // shifter takes a byte this cycle

  modport link (
    output rx_data, rx_valid, frame_end, tx_ready,
    input  tx_data, tx_valid
  );

  modport cmd (input rx_data, rx_valid, frame_end);

  modport reply (
    output tx_data, tx_valid,
    input  tx_ready, frame_end
  );
endinterface

// File: rtl/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;
  logic                              en;
  logic                              we;
  logic [trs_io_pkg::mem_addr_w-1:0] addr;
  logic [trs_io_pkg::byte_w-1:0]     wdata;
  logic [trs_io_pkg::byte_w-1:0]     rdata;
  logic                              rdata_valid;  // two cycles after a read

  modport ctrl (output en, we, addr, wdata);

  modport ram (
    input  en, we, addr, wdata,
    output rdata, rdata_valid
  );

  modport reader (input rdata, rdata_valid);
endinterface

// File: rtl/spi_link.sv
`timescale 1ns/1ps

module spi_link (
  input  logic     clk,
  input  logic     rst,
  input  logic     sck,
  input  logic     cs_n,
  input  logic     mosi,
  output logic     miso,
  spi_byte_if.link spi
);

  localparam int w = trs_io_pkg::byte_w;

  logic [2:0]           sck_q;
  logic [2:0]           cs_q;
  logic [1:0]           mosi_q;
  logic [$clog2(w)-1:0] bit_cnt;
  logic [w-1:0]         rx_shift;
  logic [w-1:0]         tx_shift;
  logic                 sck_rise;
  logic                 sck_fall;
  logic                 cs_active;

  // two-flop sync plus one stage for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q <= '0;
      cs_q  <= '1;
    end else begin
      sck_q <= {sck_q[1:0], sck};
      cs_q  <= {cs_q[1:0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[0], mosi};
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[1];

  // falling edge after the eighth bit opens the next byte slot
  assign spi.tx_ready = cs_active && sck_fall && (bit_cnt == '0);
  assign spi.rx_data  = rx_shift;  // stable until the next rising edge

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt       <= '0;
      spi.rx_valid  <= 1'b0;
      spi.frame_end <= 1'b0;
    end else begin
      spi.rx_valid  <= cs_active && sck_rise && (bit_cnt == w - 1);
      spi.frame_end <= (cs_q[2:1] == 2'b01);
      if (!cs_active)
        bit_cnt <= '0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 1'b1;  // wraps at byte boundary
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[w-2:0], mosi_q[1]};  // msb first
  end

  always_ff @(posedge clk) begin
    if (!cs_active)
      tx_shift <= '0;
    else if (spi.tx_ready)
      tx_shift <= spi.tx_valid ? spi.tx_data : '0;
    else if (sck_fall)
      tx_shift <= {tx_shift[w-2:0], 1'b0};
  end

  assign miso = tx_shift[w-1] & ~cs_n;  // no tri-state, low outside a frame

  // host must keep cs_n low until the last bit has been taken
  assert property (@(posedge clk) disable iff (rst) spi.rx_valid |-> !cs_q[1])
    else $error("spi_link: byte completed outside a frame");

endmodule

// File: rtl/cmd_ctrl.sv
`timescale 1ns/1ps

module cmd_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  spi_byte_if.cmd                       spi,
  mem_port_if.ctrl                      mem,
  output logic                          action_valid,
  output trs_io_pkg::opcode_e           action_op,
  output logic [trs_io_pkg::byte_w-1:0] action_data
);

  localparam int cnt_w = $clog2(trs_io_pkg::max_params + 1);
  localparam int idx_w = $clog2(trs_io_pkg::max_params);
  localparam int hi_w  = trs_io_pkg::mem_addr_w - trs_io_pkg::byte_w;

  trs_io_pkg::ctrl_state_e       state;
  trs_io_pkg::opcode_e           cmd;
  trs_io_pkg::opcode_e           rx_op;
  logic [cnt_w-1:0]              to_read;
  logic [idx_w-1:0]              idx;
  logic [trs_io_pkg::byte_w-1:0] params [trs_io_pkg::max_params];

  function automatic logic [cnt_w-1:0] param_count(trs_io_pkg::opcode_e op);
    case (op)
      trs_io_pkg::bram_poke: return cnt_w'(3);
      trs_io_pkg::bram_peek: return cnt_w'(2);
      trs_io_pkg::set_led:   return cnt_w'(1);
      default:               return '0;
    endcase
  endfunction

  assign rx_op = trs_io_pkg::opcode_e'(spi.rx_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= trs_io_pkg::st_idle;
      action_valid <= 1'b0;
      mem.en       <= 1'b0;
      mem.we       <= 1'b0;
    end else begin
      action_valid <= 1'b0;
      mem.en       <= 1'b0;
      mem.we       <= 1'b0;
      if (spi.frame_end) begin
        state <= trs_io_pkg::st_idle;  // partial command is dropped
      end else begin
        case (state)
          trs_io_pkg::st_idle: begin
            if (spi.rx_valid) begin
              case (rx_op)
                trs_io_pkg::get_cookie,
                trs_io_pkg::get_version,
                trs_io_pkg::get_config: action_valid <= 1'b1;
                trs_io_pkg::bram_poke,
                trs_io_pkg::bram_peek,
                trs_io_pkg::set_led: state <= trs_io_pkg::st_read_bytes;
                default: state <= trs_io_pkg::st_idle;  // unknown opcode
              endcase
            end
          end
          trs_io_pkg::st_read_bytes: begin
            if (spi.rx_valid && to_read == cnt_w'(1))
              state <= trs_io_pkg::st_execute;
          end
          trs_io_pkg::st_execute: begin
            state <= trs_io_pkg::st_idle;
            case (cmd)
              trs_io_pkg::bram_poke: begin
                mem.en <= 1'b1;
                mem.we <= 1'b1;
              end
              trs_io_pkg::bram_peek: mem.en <= 1'b1;
              default: action_valid <= 1'b1;  // set_led
            endcase
          end
          default: state <= trs_io_pkg::st_idle;
        endcase
      end
    end
  end

  // opcode and parameter capture
  always_ff @(posedge clk) begin
    if (spi.rx_valid) begin
      if (state == trs_io_pkg::st_idle) begin
        cmd     <= rx_op;
        to_read <= param_count(rx_op);
        idx     <= '0;
      end else if (state == trs_io_pkg::st_read_bytes) begin
        params[idx] <= spi.rx_data;
        idx         <= idx + 1'b1;
        to_read     <= to_read - 1'b1;
      end
    end
  end

  assign action_op   = cmd;
  assign action_data = params[0];
  assign mem.addr    = {params[1][hi_w-1:0], params[0]};  // bit 15 of the address ignored
  assign mem.wdata   = params[2];

  assert property (@(posedge clk) disable iff (rst)
    state inside {trs_io_pkg::st_idle, trs_io_pkg::st_read_bytes, trs_io_pkg::st_execute})
    else $error("cmd_ctrl: illegal state");

endmodule

// File: rtl/shadow_ram.sv
`timescale 1ns/1ps

module shadow_ram (
  input logic     clk,
  mem_port_if.ram mem
);

  logic [trs_io_pkg::byte_w-1:0] ram [trs_io_pkg::mem_depth];
  logic [trs_io_pkg::byte_w-1:0] rd_q;
  logic                          rd_q_valid;

  // array access, one cycle
  always_ff @(posedge clk) begin
    if (mem.en) begin
      if (mem.we)
        ram[mem.addr] <= mem.wdata;
      else
        rd_q <= ram[mem.addr];
    end
  end

  // output register stage
  always_ff @(posedge clk) begin
    rd_q_valid      <= mem.en & ~mem.we;
    mem.rdata       <= rd_q;
    mem.rdata_valid <= rd_q_valid;
  end

  assert property (@(posedge clk) mem.rdata_valid |-> $past(mem.en && !mem.we, 2))
    else $error("shadow_ram: rdata_valid without a read two cycles back");

endmodule

// File: rtl/status_regs.sv
`timescale 1ns/1ps

module status_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [trs_io_pkg::conf_w-1:0] conf,
  input  logic                          action_valid,
  input  trs_io_pkg::opcode_e           action_op,
  input  logic [trs_io_pkg::byte_w-1:0] action_data,
  mem_port_if.reader                    mem,
  spi_byte_if.reply                     spi,
  output logic                          led_red,
  output logic                          led_green,
  output logic                          led_blue
);

  localparam int pad_w = trs_io_pkg::byte_w - trs_io_pkg::conf_w;

  logic [trs_io_pkg::conf_w-1:0] conf_meta;
  logic [trs_io_pkg::conf_w-1:0] conf_sync;
  logic [trs_io_pkg::byte_w-1:0] reply;
  logic                          reply_load;

  always_ff @(posedge clk) begin
    conf_meta <= conf;
    conf_sync <= conf_meta;
  end

  // reply source select, peek data first
  always_comb begin
    reply      = mem.rdata;
    reply_load = mem.rdata_valid;
    if (!mem.rdata_valid && action_valid) begin
      case (action_op)
        trs_io_pkg::get_cookie: begin
          reply      = trs_io_pkg::cookie_val;
          reply_load = 1'b1;
        end
        trs_io_pkg::get_version: begin
          reply      = {trs_io_pkg::version_major, trs_io_pkg::version_minor};
          reply_load = 1'b1;
        end
        trs_io_pkg::get_config: begin
          reply      = {{pad_w{1'b0}}, conf_sync};
          reply_load = 1'b1;
        end
        default: reply_load = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      spi.tx_valid <= 1'b0;
      led_red      <= 1'b0;
      led_green    <= 1'b0;
      led_blue     <= 1'b0;
    end else begin
      if (action_valid && action_op == trs_io_pkg::set_led) begin
        led_red   <= action_data[0];
        led_green <= action_data[1];
        led_blue  <= action_data[2];
      end
      if (spi.frame_end)
        spi.tx_valid <= 1'b0;  // pending reply dies with the frame
      else if (reply_load)
        spi.tx_valid <= 1'b1;  // newer reply overwrites
      else if (spi.tx_ready)
        spi.tx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reply_load)
      spi.tx_data <= reply;
  end

endmodule

// File: rtl/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          sck,
  input  logic                          cs_n,
  input  logic                          mosi,
  output logic                          miso,
  input  logic [trs_io_pkg::conf_w-1:0] conf,
  output logic                          led_red,
  output logic                          led_green,
  output logic                          led_blue
);

  spi_byte_if spi_bus ();
  mem_port_if mem_bus ();

  // command actions towards the status block
  logic                          action_valid;
  trs_io_pkg::opcode_e           action_op;
  logic [trs_io_pkg::byte_w-1:0] action_data;

  spi_link link_i (
    .clk  (clk),
    .rst  (rst),
    .sck  (sck),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso),
    .spi  (spi_bus.link)
  );

  cmd_ctrl ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .spi          (spi_bus.cmd),
    .mem          (mem_bus.ctrl),
    .action_valid (action_valid),
    .action_op    (action_op),
    .action_data  (action_data)
  );

  shadow_ram ram_i (
    .clk (clk),
    .mem (mem_bus.ram)
  );

  status_regs status_i (
    .clk          (clk),
    .rst          (rst),
    .conf         (conf),
    .action_valid (action_valid),
    .action_op    (action_op),
    .action_data  (action_data),
    .mem          (mem_bus.reader),
    .spi          (spi_bus.reply),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue)
  );

endmodule

// File: tests/tb_trs_io.sv
`timescale 1ns/1ps

module tb_trs_io;

  // command codes as the external controller sends them
  localparam logic [7:0] op_get_cookie  = 8'h00;
  localparam logic [7:0] op_bram_poke   = 8'h01;
  localparam logic [7:0] op_bram_peek   = 8'h02;
  localparam logic [7:0] op_get_version = 8'h0F;
  localparam logic [7:0] op_set_led     = 8'h1A;
  localparam logic [7:0] op_get_config  = 8'h1B;
  localparam logic [7:0] op_unknown     = 8'h55;
  localparam logic [7:0] dummy          = 8'hFF;  // not an opcode, so no reply
  localparam int half_period = 10;                 // clocks per sck phase
  localparam int led_timeout = 100;
  localparam int num_pokes   = 8;

  logic       clk;
  logic       rst;
  logic       sck;
  logic       cs_n;
  logic       mosi;
  logic       miso;
  logic [3:0] conf;
  logic       led_red;
  logic       led_green;
  logic       led_blue;

  logic [15:0] lfsr;
  logic [15:0] poke_addr [num_pokes];
  logic [7:0]  poke_data [num_pokes];
  int          checks;
  int          errors;

  trs_io_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .conf      (conf),
    .led_red   (led_red),
    .led_green (led_green),
    .led_blue  (led_blue)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d error(s)", name, errors - err0);
  endtask

  task automatic start_frame();
    @(posedge clk);
    cs_n <= 1'b0;
    wait_clocks(4);
  endtask

  task automatic stop_frame();
    @(posedge clk);
    cs_n <= 1'b1;
    wait_clocks(6);
  endtask

  // one mode 0 byte, msb first, miso taken just before each rising sck
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    rx = '0;
    for (i = 7; i >= 0; i--) begin
      @(posedge clk);
      mosi <= tx[i];
      wait_clocks(half_period);
      @(negedge clk);
      rx[i] = miso;
      @(posedge clk);
      sck <= 1'b1;
      wait_clocks(half_period);
      @(posedge clk);
      sck <= 1'b0;
    end
    wait_clocks(half_period);  // let the last falling edge load the next reply
  endtask

  task automatic poke_byte(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] rx;
    start_frame();
    spi_xfer(op_bram_poke, rx);
    spi_xfer(addr[7:0], rx);
    spi_xfer(addr[15:8], rx);
    spi_xfer(data, rx);
    stop_frame();
  endtask

  task automatic peek_byte(input logic [15:0] addr, output logic [7:0] data);
    logic [7:0] rx;
    start_frame();
    spi_xfer(op_bram_peek, rx);
    spi_xfer(addr[7:0], rx);
    spi_xfer(addr[15:8], rx);
    spi_xfer(dummy, data);
    stop_frame();
  endtask

  // later pokes to the same 15-bit address win
  function automatic logic [7:0] last_write(input logic [14:0] a);
    logic [7:0] v;
    int j;
    v = '0;
    for (j = 0; j < num_pokes; j++)
      if (poke_addr[j][14:0] == a)
        v = poke_data[j];
    return v;
  endfunction

  task automatic test_cookie_version();
    logic [7:0] rx;
    int err0;
    err0 = errors;
    start_frame();
    spi_xfer(op_get_cookie, rx);
    spi_xfer(dummy, rx);
    check_byte("miso (get_cookie reply)", rx, 8'hAF);
    spi_xfer(op_get_version, rx);
    spi_xfer(dummy, rx);
    check_byte("miso (get_version reply)", rx, 8'h03);
    stop_frame();
    report_test("cookie_version", err0);
  endtask

  task automatic test_config();
    logic [15:0] r;
    logic [7:0]  rx;
    logic [3:0]  val;
    int k;
    int err0;
    err0 = errors;
    rand_bits(4, r);
    for (k = 0; k < 2; k++) begin
      val = (k == 0) ? r[3:0] : ~r[3:0];  // every conf bit seen both ways
      @(posedge clk);
      conf <= val;
      wait_clocks(6);  // conf passes a two-flop sync
      start_frame();
      spi_xfer(op_get_config, rx);
      spi_xfer(dummy, rx);
      check_byte("miso (get_config reply)", rx, {4'h0, val});
      stop_frame();
    end
    report_test("config", err0);
  endtask

  task automatic test_leds();
    logic [15:0] r;
    logic [7:0]  rx;
    logic [7:0]  led_arg;
    int k;
    int n;
    int err0;
    err0 = errors;
    rand_bits(8, r);
    for (k = 0; k < 2; k++) begin
      led_arg = (k == 0) ? r[7:0] : ~r[7:0];  // each led driven high and low
      start_frame();
      spi_xfer(op_set_led, rx);
      spi_xfer(led_arg, rx);
      stop_frame();
      n = 0;
      @(negedge clk);
      while ({led_blue, led_green, led_red} !== led_arg[2:0] && n < led_timeout) begin
        @(negedge clk);
        n++;
      end
      check_byte("led_blue/led_green/led_red", {5'b0, led_blue, led_green, led_red},
                 {5'b0, led_arg[2:0]});
    end
    report_test("leds", err0);
  endtask

  task automatic test_ram();
    logic [15:0] r;
    logic [7:0]  got;
    int i;
    int err0;
    err0 = errors;
    for (i = 0; i < num_pokes; i++) begin
      rand_bits(16, r);
      poke_addr[i] = r;
      rand_bits(8, r);
      poke_data[i] = r[7:0];
      poke_byte(poke_addr[i], poke_data[i]);
    end
    for (i = 0; i < num_pokes; i++) begin
      peek_byte(poke_addr[i] ^ 16'h8000, got);  // top address bit flipped
      check_byte("miso (bram_peek reply)", got, last_write(poke_addr[i][14:0]));
    end
    report_test("ram", err0);
  endtask

  task automatic test_abort_unknown();
    logic [7:0] rx;
    int err0;
    err0 = errors;
    start_frame();
    spi_xfer(op_bram_poke, rx);
    spi_xfer(poke_addr[0][7:0], rx);
    stop_frame();  // poke dropped
    peek_byte(poke_addr[0], rx);
    check_byte("miso (peek after aborted poke)", rx, last_write(poke_addr[0][14:0]));
    start_frame();
    spi_xfer(op_unknown, rx);
    check_byte("miso (first byte of frame)", rx, 8'h00);
    spi_xfer(op_get_cookie, rx);
    check_byte("miso (after unknown opcode)", rx, 8'h00);
    spi_xfer(dummy, rx);
    check_byte("miso (get_cookie reply)", rx, 8'hAF);
    spi_xfer(dummy, rx);
    check_byte("miso (no pending reply)", rx, 8'h00);
    stop_frame();
    report_test("abort_unknown", err0);
  endtask

  initial begin
    rst    = 1'b1;
    sck    = 1'b0;
    cs_n   = 1'b1;
    mosi   = 1'b0;
    conf   = 4'h0;
    lfsr   = 16'd49;
    checks = 0;
    errors = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait_clocks(4);
    test_cookie_version();
    test_config();
    test_leds();
    test_ram();
    test_abort_unknown();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: compile.f
rtl/trs_io_pkg.sv
rtl/spi_byte_if.sv
rtl/mem_port_if.sv
rtl/spi_link.sv
rtl/cmd_ctrl.sv
rtl/shadow_ram.sv
rtl/status_regs.sv
rtl/trs_io_top.sv
tests/tb_trs_io.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run the testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_trs_io -o tb_trs_io \
  && ./obj_dir/tb_trs_io > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation finished: PASS" sim.log \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }
